// ==== bench/fetch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Watches the front-end ports and checks the packet stream, the credits
// and the spacing of the pipeline enable.
module fetch_checker (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic [31:0]       clock_divider,
    input  wire logic              clk_en,
    input  wire logic              redirect,
    input  wire fetch_pkg::addr_t  redirect_pc,
    input  wire logic              mem_req_valid,
    input  wire fetch_pkg::slot_t  mem_req_tag,
    input  wire logic              credit_return,
    input  wire logic              pkt_valid,
    input  wire fetch_pkg::instr_t pkt_instr,
    input  wire fetch_pkg::addr_t  pkt_pc,
    input  wire fetch_pkg::slot_t  pkt_slot,
    output int                     error_count,
    output int                     packet_count
);

    int               credits;
    int               cycles_since;
    int               stable_cycles;
    logic             seen_enable;
    logic             have_slot;
    logic [31:0]      last_divider;
    fetch_pkg::addr_t expected_pc;
    fetch_pkg::slot_t last_slot;
    fetch_pkg::slot_t first_live_slot;
    fetch_pkg::slot_t next_free_slot;

    // Reference instruction word for a PC, a fixed mix of all its bits.
    function automatic fetch_pkg::instr_t expected_instr(input fetch_pkg::addr_t pc);
        return {pc[15:0], pc[31:16]} ^ (pc * 32'h9e37_79b9) ^ 32'h1357_9bdf;
    endfunction

    // All ports are sampled on the falling edge, where they are settled.
    always @(negedge clk) begin
        if (reset) begin
            error_count     = 0;
            packet_count    = 0;
            credits         = int'(fetch_pkg::DECODE_CREDITS);
            cycles_since    = 0;
            stable_cycles   = 0;
            seen_enable     = 1'b0;
            have_slot       = 1'b0;
            last_divider    = clock_divider;
            expected_pc     = fetch_pkg::RESET_PC;
            last_slot       = '0;
            first_live_slot = '0;
            next_free_slot  = '0;
        end else begin
            // Enable spacing is only judged once the divider has been steady
            // for longer than the period being measured.
            cycles_since++;
            if (clock_divider != last_divider) begin
                stable_cycles = 0;
            end else begin
                stable_cycles++;
            end
            last_divider = clock_divider;

            if (mem_req_valid && !clk_en) begin
                $display("[ERROR] %0t: mem_req_valid high while clk_en is low", $time);
                error_count++;
            end

            if (clk_en) begin
                if (seen_enable && stable_cycles > cycles_since + 2 &&
                        cycles_since != int'(clock_divider) + 1) begin
                    $display("[ERROR] %0t: clk_en period %0d, expected %0d",
                             $time, cycles_since, int'(clock_divider) + 1);
                    error_count++;
                end
                seen_enable  = 1'b1;
                cycles_since = 0;
            end

            // Every slot requested so far is older than the next free id.
            if (mem_req_valid) begin
                next_free_slot = mem_req_tag + fetch_pkg::slot_t'(1);
            end

            // A redirect restarts the expected stream, and every slot
            // requested before it is now stale.
            if (clk_en && redirect) begin
                expected_pc     = redirect_pc;
                first_live_slot = next_free_slot;
            end

            if (pkt_valid) begin
                packet_count++;
                if (credits == 0) begin
                    $display("[ERROR] %0t: packet sent with no credit left", $time);
                    error_count++;
                end else begin
                    credits--;
                end
                if (pkt_pc !== expected_pc) begin
                    $display("[ERROR] %0t: pkt_pc %h, expected %h", $time, pkt_pc, expected_pc);
                    error_count++;
                end
                if (pkt_instr !== expected_instr(pkt_pc)) begin
                    $display("[ERROR] %0t: pkt_instr %h for pc %h, expected %h",
                             $time, pkt_instr, pkt_pc, expected_instr(pkt_pc));
                    error_count++;
                end
                if (have_slot && pkt_slot <= last_slot) begin
                    $display("[ERROR] %0t: pkt_slot %0d does not follow slot %0d",
                             $time, pkt_slot, last_slot);
                    error_count++;
                end
                if (pkt_slot < first_live_slot) begin
                    $display("[ERROR] %0t: pkt_slot %0d was issued before the last redirect",
                             $time, pkt_slot);
                    error_count++;
                end
                last_slot   = pkt_slot;
                have_slot   = 1'b1;
                expected_pc = expected_pc + fetch_pkg::INSTR_BYTES;
            end

            if (credit_return) begin
                credits++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the fetch front end. It models the instruction memory and
// a consumer that hands credits back, and runs the test phases in turn.
module tb_fetch_frontend;

    localparam int RESET_CYCLES = 10;
    localparam int PLAIN_CYCLES = 400;
    localparam int SLOW_CYCLES  = 600;
    localparam int HOLD_CYCLES  = 80;
    localparam int QUIET_CYCLES = 20;
    localparam int DRAIN_CYCLES = 200;
    localparam int REDIRECTS    = 6;
    localparam int REDIRECT_GAP = 60;
    localparam int MIN_PACKETS  = 100;
    // A redirect is held until an enabled cycle, which takes a few clocks.
    localparam int RUN_CYCLES = RESET_CYCLES + PLAIN_CYCLES + SLOW_CYCLES + HOLD_CYCLES +
                                QUIET_CYCLES + 2 * DRAIN_CYCLES +
                                REDIRECTS * (REDIRECT_GAP + 4);
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 500;

    logic              clk = 1'b0;
    logic              reset;
    logic [31:0]       clock_divider;
    logic              redirect;
    fetch_pkg::addr_t  redirect_pc;
    logic              mem_accepted = 1'b0;
    fetch_pkg::instr_t mem_data = '0;
    fetch_pkg::slot_t  mem_data_tag = '1;
    logic              credit_return = 1'b0;

    logic              clk_en;
    logic              mem_req_valid;
    fetch_pkg::addr_t  mem_req_pc;
    fetch_pkg::slot_t  mem_req_tag;
    logic              pkt_valid;
    fetch_pkg::instr_t pkt_instr;
    fetch_pkg::addr_t  pkt_pc;
    fetch_pkg::slot_t  pkt_slot;

    int                error_count;
    int                packet_count;
    int                bench_errors = 0;
    logic              withhold;
    logic [31:0]       lfsr = 32'he92b;

    // Memory return pipeline. It moves one step per enabled cycle.
    logic              near_valid = 1'b0;
    fetch_pkg::addr_t  near_pc = '0;
    fetch_pkg::slot_t  near_tag = '0;
    logic              far_valid = 1'b0;
    fetch_pkg::addr_t  far_pc = '0;
    fetch_pkg::slot_t  far_tag = '0;
    int                received = 0;
    int                returned = 0;

    fetch_frontend uut (
        .clk           (clk),
        .reset         (reset),
        .clock_divider (clock_divider),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .mem_accepted  (mem_accepted),
        .mem_data      (mem_data),
        .mem_data_tag  (mem_data_tag),
        .credit_return (credit_return),
        .clk_en        (clk_en),
        .mem_req_valid (mem_req_valid),
        .mem_req_pc    (mem_req_pc),
        .mem_req_tag   (mem_req_tag),
        .pkt_valid     (pkt_valid),
        .pkt_instr     (pkt_instr),
        .pkt_pc        (pkt_pc),
        .pkt_slot      (pkt_slot)
    );

    fetch_checker u_fetch_checker (
        .clk           (clk),
        .reset         (reset),
        .clock_divider (clock_divider),
        .clk_en        (clk_en),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .mem_req_valid (mem_req_valid),
        .mem_req_tag   (mem_req_tag),
        .credit_return (credit_return),
        .pkt_valid     (pkt_valid),
        .pkt_instr     (pkt_instr),
        .pkt_pc        (pkt_pc),
        .pkt_slot      (pkt_slot),
        .error_count   (error_count),
        .packet_count  (packet_count)
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function logic next_random_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    // Contents of the instruction memory, a fixed mix of the whole address.
    function automatic fetch_pkg::instr_t memory_word(input fetch_pkg::addr_t pc);
        return {pc[15:0], pc[31:16]} ^ (pc * 32'h9e37_79b9) ^ 32'h1357_9bdf;
    endfunction

    // Holds redirect until the front end has seen it in an enabled cycle.
    task automatic send_redirect(input fetch_pkg::addr_t target);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(negedge clk);
        while (!clk_en) begin
            @(negedge clk);
        end
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    // Requests taken and packets received are picked up on the falling edge.
    always @(negedge clk) begin
        if (reset) begin
            near_valid = 1'b0;
            far_valid  = 1'b0;
        end else begin
            if (clk_en) begin
                far_valid  = near_valid;
                far_pc     = near_pc;
                far_tag    = near_tag;
                near_valid = mem_req_valid && mem_accepted;
                near_pc    = mem_req_pc;
                near_tag   = mem_req_tag;
            end
            if (pkt_valid) begin
                received++;
            end
        end
    end

    // The far entry is on the bus through the second enabled cycle after
    // its request. Credits go back one at a time at random.
    always @(posedge clk) begin
        logic accept_a;
        logic accept_b;
        if (reset) begin
            mem_accepted  <= 1'b0;
            mem_data      <= '0;
            mem_data_tag  <= '1;
            credit_return <= 1'b0;
        end else begin
            // About three requests in four are taken.
            accept_a = next_random_bit();
            accept_b = next_random_bit();
            mem_accepted <= accept_a | accept_b;
            if (far_valid) begin
                mem_data     <= memory_word(far_pc);
                mem_data_tag <= far_tag;
            end else begin
                mem_data     <= '0;
                mem_data_tag <= '1;
            end
            if (!withhold && returned < received && next_random_bit()) begin
                credit_return <= 1'b1;
                returned++;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    initial begin : run_phases
        int quiet_requests;
        int step;
        reset          = 1'b1;
        clock_divider  = 32'd0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        withhold       = 1'b0;
        quiet_requests = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Full speed first, then one enabled cycle in every three clocks.
        repeat (PLAIN_CYCLES) @(posedge clk);
        clock_divider <= 32'd2;
        repeat (SLOW_CYCLES) @(posedge clk);
        clock_divider <= 32'd0;

        // The consumer keeps its credits until the queue fills and fetch stops.
        withhold <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (mem_req_valid) begin
                quiet_requests++;
            end
        end
        if (quiet_requests != 0) begin
            $display("[ERROR] %0t: %0d fetch requests while the queue was held full",
                     $time, quiet_requests);
            bench_errors++;
        end
        @(posedge clk);
        withhold <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);

        // Redirects mid-run, the second half of them with a divider of one.
        for (step = 0; step < REDIRECTS; step++) begin
            if (step == REDIRECTS / 2) begin
                clock_divider <= 32'd1;
            end
            repeat (REDIRECT_GAP) @(posedge clk);
            send_redirect(32'h0000_4000 + step * 32'h0001_0104);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);

        if (packet_count < MIN_PACKETS) begin
            $display("Only %0d packets reached the consumer", packet_count);
            bench_errors++;
        end
        $display("Packets: %0d, checker errors: %0d, testbench errors: %0d",
                 packet_count, error_count, bench_errors);
        if (error_count == 0 && bench_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/clock_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

// Memory-mapped clock divider. A value of zero runs the pipeline on every
// clock; a value of N gives one enabled cycle in every N+1 clocks.
module clock_divider (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [31:0] clock_divider,
    output logic             clk_en,
    output logic             pipe_en
);

    logic [31:0] div_count;

    // The first cycle after reset is always an enabled one.
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_en    <= 1'b1;
            div_count <= 32'd0;
        end else if (clock_divider == 32'd0) begin
            clk_en    <= 1'b1;
            div_count <= 32'd0;
        end else if (div_count >= clock_divider) begin
            // End of the period. Restart the count.
            clk_en    <= 1'b1;
            div_count <= 32'd0;
        end else begin
            clk_en    <= 1'b0;
            div_count <= div_count + 32'd1;
        end
    end

    // The pipeline sees the same enable that is shown at the top level.
    assign pipe_en = clk_en;

endmodule

`default_nettype wire

// ==== design/fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

// Instruction-fetch front end: clock divider, fetch issue, tracking stages
// and the packet queue toward the consumer.
module fetch_frontend (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic [31:0]       clock_divider,
    input  wire logic              redirect,
    input  wire fetch_pkg::addr_t  redirect_pc,
    input  wire logic              mem_accepted,
    input  wire fetch_pkg::instr_t mem_data,
    input  wire fetch_pkg::slot_t  mem_data_tag,
    input  wire logic              credit_return,
    output logic                   clk_en,
    output logic                   mem_req_valid,
    output fetch_pkg::addr_t       mem_req_pc,
    output fetch_pkg::slot_t       mem_req_tag,
    output logic                   pkt_valid,
    output fetch_pkg::instr_t      pkt_instr,
    output fetch_pkg::addr_t       pkt_pc,
    output fetch_pkg::slot_t       pkt_slot
);

    logic             pipe_en;
    logic             replay;
    fetch_pkg::addr_t replay_pc;
    logic             issue_stop;

    issue_if issue_bus ();
    slot_if  slot_bus ();

    clock_divider u_clock_divider (
        .clk           (clk),
        .reset         (reset),
        .clock_divider (clock_divider),
        .clk_en        (clk_en),
        .pipe_en       (pipe_en)
    );

    fetch_pc_gen u_fetch_pc_gen (
        .clk           (clk),
        .reset         (reset),
        .pipe_en       (pipe_en),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .replay        (replay),
        .replay_pc     (replay_pc),
        .issue_stop    (issue_stop),
        .mem_accepted  (mem_accepted),
        .mem_req_valid (mem_req_valid),
        .mem_req_pc    (mem_req_pc),
        .mem_req_tag   (mem_req_tag),
        .issue         (issue_bus.source)
    );

    fetch_track u_fetch_track (
        .clk       (clk),
        .reset     (reset),
        .pipe_en   (pipe_en),
        .redirect  (redirect),
        .issue     (issue_bus.sink),
        .slot_out  (slot_bus.source),
        .replay    (replay),
        .replay_pc (replay_pc)
    );

    frontend_queue u_frontend_queue (
        .clk           (clk),
        .reset         (reset),
        .pipe_en       (pipe_en),
        .redirect      (redirect),
        .mem_data      (mem_data),
        .mem_data_tag  (mem_data_tag),
        .credit_return (credit_return),
        .slot_in       (slot_bus.sink),
        .issue_stop    (issue_stop),
        .pkt_valid     (pkt_valid),
        .pkt_instr     (pkt_instr),
        .pkt_pc        (pkt_pc),
        .pkt_slot      (pkt_slot)
    );

endmodule

`default_nettype wire

// ==== design/fetch_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// One fetch request per enabled cycle, reported together with the
// answer the instruction memory gave in that same cycle.
interface issue_if;
    logic             valid;
    fetch_pkg::addr_t pc;
    fetch_pkg::slot_t slot;
    logic             accepted;

    modport source (
        output valid,
        output pc,
        output slot,
        output accepted
    );

    modport sink (
        input valid,
        input pc,
        input slot,
        input accepted
    );
endinterface

// An accepted slot that has reached the second tracking stage.
interface slot_if;
    logic             live;
    fetch_pkg::addr_t pc;
    fetch_pkg::slot_t slot;

    modport source (
        output live,
        output pc,
        output slot
    );

    modport sink (
        input live,
        input pc,
        input slot
    );
endinterface

`default_nettype wire

// ==== design/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Fetch PC and slot id generator. It drives the instruction-memory request
// and reports every request, with its accept flag, to the tracking stages.
module fetch_pc_gen (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             pipe_en,
    input  wire logic             redirect,
    input  wire fetch_pkg::addr_t redirect_pc,
    input  wire logic             replay,
    input  wire fetch_pkg::addr_t replay_pc,
    input  wire logic             issue_stop,
    input  wire logic             mem_accepted,
    output logic                  mem_req_valid,
    output fetch_pkg::addr_t      mem_req_pc,
    output fetch_pkg::slot_t      mem_req_tag,
    issue_if.source               issue
);

    fetch_pkg::addr_t fetch_pc;
    fetch_pkg::slot_t slot_id;

    // A redirect or replay cycle loads a new PC instead of requesting, so
    // the request is dropped in the cycle either one is seen.
    assign mem_req_valid = pipe_en && !issue_stop && !redirect && !replay;
    assign mem_req_pc    = fetch_pc;
    assign mem_req_tag   = slot_id;

    assign issue.valid    = mem_req_valid;
    assign issue.pc       = fetch_pc;
    assign issue.slot     = slot_id;
    assign issue.accepted = mem_accepted;

    // The slot id steps on every request, accepted or not. A replayed PC
    // therefore goes out again under a new, larger slot id.
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= fetch_pkg::RESET_PC;
            slot_id  <= '0;
        end else if (pipe_en) begin
            if (redirect) begin
                fetch_pc <= redirect_pc;
            end else if (replay) begin
                fetch_pc <= replay_pc;
            end else if (mem_req_valid) begin
                fetch_pc <= fetch_pc + fetch_pkg::INSTR_BYTES;
                slot_id  <= slot_id + fetch_pkg::slot_t'(1);
            end
        end
    end

    // Slot ids only count up, so one can repeat only after the counter
    // wraps. Requests stay short of the all-ones id.
    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> mem_req_tag != '1);

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`default_nettype none

// Widths, sizes and types shared by the instruction-fetch front end.
package fetch_pkg;

    // Byte address of an instruction.
    typedef logic [31:0] addr_t;

    // Instruction word as returned by the instruction memory.
    typedef logic [31:0] instr_t;

    // Fetch slot id. The same value goes out as the memory request tag.
    typedef logic [31:0] slot_t;

    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = 3;
    localparam int QUEUE_COUNT_W = 4;

    typedef logic [QUEUE_COUNT_W-1:0] queue_count_t;

    // New fetch issue stops at this fill level. The two entries above it
    // take the slots that are still in the tracking stages.
    localparam queue_count_t QUEUE_STOP_LEVEL = 4'd6;

    typedef logic [2:0] credit_count_t;

    // Size of the buffer on the consumer side.
    localparam credit_count_t DECODE_CREDITS = 3'd4;

    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam addr_t INSTR_BYTES = 32'd4;

    typedef enum logic [1:0] {
        QUEUE_EMPTY,
        QUEUE_FILLING,
        QUEUE_STOPPING,
        QUEUE_FULL
    } queue_state_e;

endpackage

`default_nettype wire

// ==== design/fetch_track.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two tracking stages that follow each request until its instruction word
// comes back. Stage two lines up with the memory return.
module fetch_track (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        pipe_en,
    input  wire logic        redirect,
    issue_if.sink            issue,
    slot_if.source           slot_out,
    output logic             replay,
    output fetch_pkg::addr_t replay_pc
);

    logic             stage1_valid;
    logic             stage1_accepted;
    fetch_pkg::addr_t stage1_pc;
    fetch_pkg::slot_t stage1_slot;

    logic             stage2_valid;
    logic             stage2_accepted;
    fetch_pkg::addr_t stage2_pc;
    fetch_pkg::slot_t stage2_slot;

    logic             flush;

    // A slot the memory refused is fetched again from its own PC.
    assign replay    = stage2_valid && !stage2_accepted;
    assign replay_pc = stage2_pc;

    // Both a redirect and a replay restart fetch, so every younger slot in
    // the stages is stale and goes away.
    assign flush = redirect || replay;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage1_valid    <= 1'b0;
            stage1_accepted <= 1'b0;
            stage2_valid    <= 1'b0;
            stage2_accepted <= 1'b0;
        end else if (pipe_en) begin
            if (flush) begin
                stage1_valid    <= 1'b0;
                stage1_accepted <= 1'b0;
                stage2_valid    <= 1'b0;
                stage2_accepted <= 1'b0;
            end else begin
                stage1_valid    <= issue.valid;
                stage1_accepted <= issue.accepted;
                stage2_valid    <= stage1_valid;
                stage2_accepted <= stage1_accepted;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            stage1_pc   <= issue.pc;
            stage1_slot <= issue.slot;
            stage2_pc   <= stage1_pc;
            stage2_slot <= stage1_slot;
        end
    end

    assign slot_out.live = stage2_valid && stage2_accepted;
    assign slot_out.pc   = stage2_pc;
    assign slot_out.slot = stage2_slot;

endmodule

`default_nettype wire

// ==== design/frontend_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

// Front-end packet queue. A returned word is paired with its slot by tag,
// queued with its PC and slot id, and sent to the consumer under credits.
module frontend_queue (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              pipe_en,
    input  wire logic              redirect,
    input  wire fetch_pkg::instr_t mem_data,
    input  wire fetch_pkg::slot_t  mem_data_tag,
    input  wire logic              credit_return,
    slot_if.sink                   slot_in,
    output logic                   issue_stop,
    output logic                   pkt_valid,
    output fetch_pkg::instr_t      pkt_instr,
    output fetch_pkg::addr_t       pkt_pc,
    output fetch_pkg::slot_t       pkt_slot
);

    fetch_pkg::instr_t queue_instr [fetch_pkg::QUEUE_DEPTH];
    fetch_pkg::addr_t  queue_pc    [fetch_pkg::QUEUE_DEPTH];
    fetch_pkg::slot_t  queue_slot  [fetch_pkg::QUEUE_DEPTH];

    logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    fetch_pkg::queue_count_t           fill_count;
    fetch_pkg::queue_state_e           fill_state;
    fetch_pkg::credit_count_t          credits;

    logic tag_hit;
    logic push_req;
    logic push;
    logic pop;

    always_comb begin
        if (fill_count == '0) begin
            fill_state = fetch_pkg::QUEUE_EMPTY;
        end else if (fill_count == fetch_pkg::queue_count_t'(fetch_pkg::QUEUE_DEPTH)) begin
            fill_state = fetch_pkg::QUEUE_FULL;
        end else if (fill_count >= fetch_pkg::QUEUE_STOP_LEVEL) begin
            fill_state = fetch_pkg::QUEUE_STOPPING;
        end else begin
            fill_state = fetch_pkg::QUEUE_FILLING;
        end
    end

    assign issue_stop = (fill_state == fetch_pkg::QUEUE_STOPPING) ||
                        (fill_state == fetch_pkg::QUEUE_FULL);

    // The tag is what pairs a word with its slot.
    assign tag_hit  = slot_in.live && (slot_in.slot == mem_data_tag);
    assign push_req = pipe_en && !redirect && tag_hit;

    // The head leaves while the consumer still has room for it.
    assign pop = pipe_en && !redirect && (fill_state != fetch_pkg::QUEUE_EMPTY) &&
                 (credits != '0);

    // A full queue still takes a word when the head leaves in the same cycle.
    assign push = push_req && ((fill_state != fetch_pkg::QUEUE_FULL) || pop);

    assign pkt_valid = pop;
    assign pkt_instr = queue_instr[rd_ptr];
    assign pkt_pc    = queue_pc[rd_ptr];
    assign pkt_slot  = queue_slot[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            fill_count <= '0;
        end else if (pipe_en && redirect) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            fill_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: fill_count <= fill_count + 1'b1;
                2'b01: fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue_instr[wr_ptr] <= mem_data;
            queue_pc[wr_ptr]    <= slot_in.pc;
            queue_slot[wr_ptr]  <= slot_in.slot;
        end
    end

    // The consumer returns credits on its own timing, so returns count on
    // every clock. A redirect leaves the credits alone.
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= fetch_pkg::DECODE_CREDITS;
        end else begin
            case ({pop, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Issue stops early enough that the slots in flight always find room.
    assert property (@(posedge clk) disable iff (reset)
        push_req |-> (fill_state != fetch_pkg::QUEUE_FULL) || pop);

    // The consumer never hands back more credits than it was given.
    assert property (@(posedge clk) disable iff (reset)
        credits <= fetch_pkg::DECODE_CREDITS);

endmodule

`default_nettype wire

// ==== files.f ====
design/fetch_pkg.sv
design/fetch_ifs.sv
design/clock_divider.sv
design/fetch_pc_gen.sv
design/fetch_track.sv
design/frontend_queue.sv
design/fetch_frontend.sv
bench/fetch_checker.sv
bench/tb_fetch_frontend.sv

// ==== run.sh ====
#!/bin/sh
# Builds the fetch front end and its testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_fetch_frontend -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_fetch_frontend)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
echo "Simulation reported a failure"
exit 1
